//--- dcache_top.f
hw/dcache_pkg.sv
hw/dcache_fill_if.sv
hw/dcache_tag_array.sv
hw/dcache_data_array.sv
hw/dcache_repl_policy.sv
hw/dcache_miss_ctrl.sv
hw/dcache_top.sv
dv/dcache_mem_model.sv
dv/dcache_tb.sv

//--- dv/dcache_mem_model.sv
module dcache_mem_model #(
	parameter int SEED = 22
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_rd_req,
	input  dcache_pkg::dc_addr_u i_rd_addr,
	output logic                 o_rd_gnt,
	output logic                 o_rvalid,
	output dcache_pkg::dc_word_t o_rdata,
	input  logic                 i_wr_req,
	input  dcache_pkg::dc_addr_u i_wr_addr,
	output logic                 o_wr_gnt,
	input  logic                 i_wvalid,
	input  dcache_pkg::dc_word_t i_wdata,
	input  logic                 i_wlast,
	output logic                 o_wready
);
	import dcache_pkg::*;

	dc_word_t mem [dc_word_t]; // Sparse, flushed words only
	dc_addr_u rd_log [$];      // Refill line addresses
	dc_addr_u wr_log [$];      // Flush line addresses
	dc_word_t wdata_log [$];   // Flush words in bus order
	int       proto_errs = 0;

	// Untouched words follow the address pattern
	function automatic dc_word_t read_word(dc_word_t addr);
		if (mem.exists(addr))
			return mem[addr];
		return addr ^ 32'hA5A5A5A5;
	endfunction

	// Random stall of 0 to 3 cycles
	task automatic gap();
		repeat ($urandom % 4) @(negedge clk);
	endtask

	task automatic refill(dc_addr_u addr);
		rd_log.push_back(addr);
		gap();
		o_rd_gnt = 1'b1;
		@(negedge clk);
		o_rd_gnt = 1'b0;
		for (int w = 0; w < DC_LINE_WORDS; w++) begin
			gap(); // Hole in rvalid
			o_rvalid = 1'b1;
			o_rdata  = read_word(addr.raw + 4 * w);
			@(negedge clk);
			o_rvalid = 1'b0;
		end
	endtask

	task automatic flush(dc_addr_u addr);
		wr_log.push_back(addr);
		gap();
		o_wr_gnt = 1'b1;
		@(negedge clk);
		o_wr_gnt = 1'b0;
		for (int w = 0; w < DC_LINE_WORDS; w++) begin
			gap(); // wready low, DUT must hold the word
			if (!i_wvalid || (i_wlast != (w == DC_LINE_WORDS - 1))) begin
				$display("Memory model: wvalid or wlast wrong on flush word %0d at time %0t",
					w, $time);
				proto_errs++;
			end
			o_wready = 1'b1;
			wdata_log.push_back(i_wdata);
			mem[addr.raw + 4 * w] = i_wdata; // Later refills see the flushed data
			@(negedge clk);
			o_wready = 1'b0;
		end
	endtask

	initial begin
		o_rd_gnt = 1'b0;
		o_rvalid = 1'b0;
		o_rdata  = '0;
		o_wr_gnt = 1'b0;
		o_wready = 1'b0;
		void'($urandom(SEED)); // Only process drawing random numbers
		forever begin
			@(negedge clk);
			if (rst_n && i_wr_req)
				flush(i_wr_addr);
			else if (rst_n && i_rd_req)
				refill(i_rd_addr);
		end
	end

endmodule

//--- dv/dcache_tb.sv
module dcache_tb;
	import dcache_pkg::*;

	typedef struct packed {
		logic       write;
		dc_tag_t    tag;
		dc_index_t  index;
		dc_offset_t offset;
		dc_word_t   wdata;
	} row_t;

	localparam int N_ROWS    = 36;
	localparam int RESET_CYC = 16;
	localparam int ROW_CYC   = 2 * (DC_LINE_WORDS * 4 + 8); // Flush plus refill, slowest memory
	localparam int LIMIT     = N_ROWS * ROW_CYC * 10 + (RESET_CYC + 2) * 10;

	// Set 3 basics, set 15 LIP leader, set 8 BIP leader, set 5 follower
	row_t tbl [N_ROWS] = '{
		'{1'b0, 24'h1, 4'd3, 2'd1, 32'h0}, // Cold miss
		'{1'b0, 24'h1, 4'd3, 2'd0, 32'h0}, // Same line, hits
		'{1'b0, 24'h1, 4'd3, 2'd2, 32'h0},
		'{1'b0, 24'h1, 4'd3, 2'd3, 32'h0},
		'{1'b1, 24'h1, 4'd3, 2'd2, 32'h1111_0002}, // Write hit
		'{1'b0, 24'h1, 4'd3, 2'd2, 32'h0},
		'{1'b0, 24'h2, 4'd3, 2'd0, 32'h0},
		'{1'b0, 24'h3, 4'd3, 2'd0, 32'h0},
		'{1'b0, 24'h4, 4'd3, 2'd0, 32'h0}, // Set 3 full
		'{1'b0, 24'h5, 4'd3, 2'd3, 32'h0}, // Dirty victim
		'{1'b0, 24'h1, 4'd3, 2'd2, 32'h0}, // Clean victim, written word back
		'{1'b1, 24'h1, 4'd15, 2'd0, 32'hAAAA_0001},
		'{1'b1, 24'h2, 4'd15, 2'd1, 32'hAAAA_0002},
		'{1'b1, 24'h3, 4'd15, 2'd2, 32'hAAAA_0003},
		'{1'b1, 24'h4, 4'd15, 2'd3, 32'hAAAA_0004},
		'{1'b0, 24'h2, 4'd15, 2'd1, 32'h0},
		'{1'b0, 24'h1, 4'd15, 2'd0, 32'h0},
		'{1'b0, 24'h5, 4'd15, 2'd0, 32'h0},
		'{1'b0, 24'h3, 4'd15, 2'd2, 32'h0}, // Re-miss on the evicted line
		'{1'b1, 24'h1, 4'd8, 2'd0, 32'hBBBB_0001},
		'{1'b1, 24'h2, 4'd8, 2'd0, 32'hBBBB_0002},
		'{1'b1, 24'h3, 4'd8, 2'd0, 32'hBBBB_0003},
		'{1'b1, 24'h4, 4'd8, 2'd0, 32'hBBBB_0004},
		'{1'b0, 24'h3, 4'd8, 2'd0, 32'h0},
		'{1'b0, 24'h5, 4'd8, 2'd1, 32'h0},
		'{1'b0, 24'h6, 4'd8, 2'd2, 32'h0},
		'{1'b0, 24'h1, 4'd8, 2'd0, 32'h0},
		'{1'b1, 24'h1, 4'd5, 2'd3, 32'hCCCC_0001},
		'{1'b0, 24'h2, 4'd5, 2'd0, 32'h0},
		'{1'b0, 24'h3, 4'd5, 2'd0, 32'h0},
		'{1'b1, 24'h4, 4'd5, 2'd1, 32'hCCCC_0002},
		'{1'b0, 24'h1, 4'd5, 2'd3, 32'h0},
		'{1'b0, 24'h5, 4'd5, 2'd0, 32'h0},
		'{1'b0, 24'h6, 4'd5, 2'd0, 32'h0},
		'{1'b0, 24'h7, 4'd5, 2'd2, 32'h0},
		'{1'b0, 24'h4, 4'd5, 2'd1, 32'h0}  // Flushed word comes back
	};

	logic                 clk = 1'b0;
	logic                 rst_n;
	logic                 req_valid, req_write;
	dc_addr_u             req_addr;
	dc_word_t             req_wdata, rsp_rdata;
	logic                 rsp_valid;
	logic                 mem_rd_req, mem_rd_gnt, mem_rvalid;
	logic [DC_ADDR_W-1:0] mem_rd_addr, mem_wr_addr;
	dc_word_t             mem_rdata, mem_wdata;
	logic                 mem_wr_req, mem_wr_gnt, mem_wvalid, mem_wlast, mem_wready;

	// Reference model
	logic     m_valid [DC_WAYS][DC_SETS];
	logic     m_dirty [DC_WAYS][DC_SETS];
	dc_tag_t  m_tag   [DC_WAYS][DC_SETS];
	int       m_order [DC_SETS][DC_WAYS]; // [0] least recent
	int       m_psel;
	int       m_bip;
	dc_word_t golden [dc_word_t];          // Latest store per word address

	// Expectations for the current row
	bit       exp_flush, exp_refill;
	dc_addr_u exp_flush_addr, exp_refill_addr;
	dc_word_t exp_line [DC_LINE_WORDS];
	dc_word_t exp_rdata;
	int       err_mis   = 0;
	int       err_other = 0;

	always #5 clk = ~clk;

	dcache_top i_dut (
		.clk, .rst_n,
		.i_req_valid  (req_valid),
		.i_req_write  (req_write),
		.i_req_addr   (req_addr),
		.i_req_wdata  (req_wdata),
		.o_rsp_valid  (rsp_valid),
		.o_rsp_rdata  (rsp_rdata),
		.o_mem_rd_req (mem_rd_req),
		.o_mem_rd_addr(mem_rd_addr),
		.i_mem_rd_gnt (mem_rd_gnt),
		.i_mem_rvalid (mem_rvalid),
		.i_mem_rdata  (mem_rdata),
		.o_mem_wr_req (mem_wr_req),
		.o_mem_wr_addr(mem_wr_addr),
		.i_mem_wr_gnt (mem_wr_gnt),
		.o_mem_wvalid (mem_wvalid),
		.o_mem_wdata  (mem_wdata),
		.o_mem_wlast  (mem_wlast),
		.i_mem_wready (mem_wready)
	);

	dcache_mem_model #(.SEED(22)) u_mem (
		.clk, .rst_n,
		.i_rd_req (mem_rd_req),
		.i_rd_addr(mem_rd_addr),
		.o_rd_gnt (mem_rd_gnt),
		.o_rvalid (mem_rvalid),
		.o_rdata  (mem_rdata),
		.i_wr_req (mem_wr_req),
		.i_wr_addr(mem_wr_addr),
		.o_wr_gnt (mem_wr_gnt),
		.i_wvalid (mem_wvalid),
		.i_wdata  (mem_wdata),
		.i_wlast  (mem_wlast),
		.o_wready (mem_wready)
	);

	function automatic dc_addr_u make_addr(dc_tag_t tag, dc_index_t index, dc_offset_t offset);
		dc_addr_u a;
		a          = '0;
		a.f.tag    = tag;
		a.f.index  = index;
		a.f.offset = offset;
		return a;
	endfunction

	function automatic dc_word_t golden_word(dc_word_t addr);
		if (golden.exists(addr))
			return golden[addr];
		return addr ^ 32'hA5A5A5A5; // Memory pattern
	endfunction

	// Move a way to the MRU end or the LRU end of its set
	task automatic place(int set, int way, bit mru);
		int q [$];
		for (int p = 0; p < DC_WAYS; p++)
			if (m_order[set][p] != way)
				q.push_back(m_order[set][p]);
		if (mru)
			q.push_back(way);
		else
			q.push_front(way);
		for (int p = 0; p < DC_WAYS; p++)
			m_order[set][p] = q[p];
	endtask

	task automatic predict(row_t r);
		int       set;
		int       way;
		int       hit_way;
		bit       set_bip;
		bit       ins_mru;
		dc_addr_u waddr;
		set        = int'(r.index);
		waddr      = make_addr(r.tag, r.index, r.offset);
		hit_way    = -1;
		exp_flush  = 1'b0;
		exp_refill = 1'b0;
		for (int w = 0; w < DC_WAYS; w++)
			if (m_valid[w][set] && m_tag[w][set] == r.tag)
				hit_way = w;
		if (hit_way < 0) begin
			way = -1;
			for (int w = DC_WAYS - 1; w >= 0; w--)
				if (!m_valid[w][set])
					way = w; // Lowest invalid wins
			if (way < 0)
				way = m_order[set][0];
			if (m_valid[way][set] && m_dirty[way][set]) begin
				exp_flush      = 1'b1;
				exp_flush_addr = make_addr(m_tag[way][set], r.index, 2'd0);
				for (int o = 0; o < DC_LINE_WORDS; o++)
					exp_line[o] = golden_word(exp_flush_addr.raw + 4 * o);
			end
			exp_refill      = 1'b1;
			exp_refill_addr = make_addr(r.tag, r.index, 2'd0);
			// Rule and counter taken before this miss counts
			set_bip = (set == DC_BIP_LEADER) ||
				(set != DC_LIP_LEADER && m_psel >= DC_PSEL_INIT);
			ins_mru = set_bip && (m_bip == 0);
			if (set == DC_BIP_LEADER && m_psel > 0)
				m_psel--;
			else if (set == DC_LIP_LEADER && m_psel < (1 << DC_PSEL_W) - 1)
				m_psel++;
			m_bip = (m_bip + 1) % (1 << DC_BIP_PERIOD_W);
			m_valid[way][set] = 1'b1;
			m_dirty[way][set] = 1'b0;
			m_tag[way][set]   = r.tag;
			place(set, way, ins_mru);
			hit_way = way;
		end
		place(set, hit_way, 1'b1); // Replayed request is a hit too
		exp_rdata = golden_word(waddr.raw);
		if (r.write) begin
			m_dirty[hit_way][set] = 1'b1;
			golden[waddr.raw]     = r.wdata;
		end
	endtask

	task automatic check_word(dc_word_t got, dc_word_t exp, string what);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
			err_mis++;
		end
	endtask

	task automatic check_addr(dc_addr_u got, dc_addr_u exp, string what);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got.raw, exp.raw);
			err_mis++;
		end
	endtask

	task automatic report_failure(string msg);
		$display("Error at time %0t: %s", $time, msg);
		err_other++;
	endtask

	initial begin
		#(LIMIT);
		$display("Timeout: the table did not finish within %0d time units", LIMIT);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		int       n_rd, n_wr, n_wd;
		dc_word_t got;
		rst_n     = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr  = '0;
		req_wdata = '0;
		m_psel    = DC_PSEL_INIT;
		m_bip     = 0;
		for (int s = 0; s < DC_SETS; s++)
			for (int w = 0; w < DC_WAYS; w++) begin
				m_valid[w][s] = 1'b0;
				m_dirty[w][s] = 1'b0;
				m_tag[w][s]   = '0;
				m_order[s][w] = w; // Way 0 least recent
			end
		repeat (RESET_CYC) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		for (int i = 0; i < N_ROWS; i++) begin
			n_rd = u_mem.rd_log.size();
			n_wr = u_mem.wr_log.size();
			n_wd = u_mem.wdata_log.size();
			predict(tbl[i]);
			req_valid = 1'b1;
			req_write = tbl[i].write;
			req_addr  = make_addr(tbl[i].tag, tbl[i].index, tbl[i].offset);
			req_wdata = tbl[i].wdata;
			// Pre-edge values, inputs only move on the falling edge
			do
				@(posedge clk);
			while (!rsp_valid);
			got = rsp_rdata;
			@(negedge clk);
			req_valid = 1'b0;
			if (!tbl[i].write)
				check_word(got, exp_rdata, $sformatf("row %0d read data", i));
			if (u_mem.rd_log.size() != n_rd + exp_refill)
				report_failure($sformatf("row %0d made %0d refill requests instead of %0d",
					i, u_mem.rd_log.size() - n_rd, exp_refill));
			else if (exp_refill)
				check_addr(u_mem.rd_log[n_rd], exp_refill_addr,
					$sformatf("row %0d refill address", i));
			if (u_mem.wr_log.size() != n_wr + exp_flush ||
			    u_mem.wdata_log.size() != n_wd + (exp_flush ? DC_LINE_WORDS : 0)) begin
				report_failure($sformatf("row %0d flush burst count is wrong", i));
			end else if (exp_flush) begin
				check_addr(u_mem.wr_log[n_wr], exp_flush_addr,
					$sformatf("row %0d flush address", i));
				for (int o = 0; o < DC_LINE_WORDS; o++)
					check_word(u_mem.wdata_log[n_wd + o], exp_line[o],
						$sformatf("row %0d flush word %0d", i, o));
			end
		end
		repeat (2) @(negedge clk);
		$display("Errors: %0d mismatches, %0d other failures, %0d memory protocol errors",
			err_mis, err_other, u_mem.proto_errs);
		if (err_mis + err_other + u_mem.proto_errs == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- hw/dcache_data_array.sv
module dcache_data_array (
	input  logic                   clk,
	input  dcache_pkg::dc_index_t  i_index,
	input  dcache_pkg::dc_offset_t i_offset,
	input  dcache_pkg::dc_way_t    i_way,        // Matching way
	input  logic                   i_store_en,
	input  dcache_pkg::dc_word_t   i_store_data,
	input  dcache_pkg::dc_way_t    i_victim_way,
	dcache_fill_if.array           fill,
	output dcache_pkg::dc_word_t   o_rdata,
	output dcache_pkg::dc_line_t   o_victim_line
);
	import dcache_pkg::*;

	dc_word_t mem [DC_WAYS][DC_SETS][DC_LINE_WORDS];

	// Hit read
	assign o_rdata = mem[i_way][i_index][i_offset];

	// Whole victim line, captured by the controller when the miss starts
	always_comb begin
		for (int o = 0; o < DC_LINE_WORDS; o++)
			o_victim_line[o] = mem[i_victim_way][i_index][o];
	end

	// Fill and store never overlap, fill wins anyway
	always_ff @(posedge clk) begin
		if (fill.fill_we)
			mem[fill.fill_way][fill.fill_index][fill.fill_offset] <= fill.fill_data;
		else if (i_store_en)
			mem[i_way][i_index][i_offset] <= i_store_data;
	end

	// fill_done is the tag array's business
	// this array only follows the per-word strobes

endmodule

//--- hw/dcache_fill_if.sv
interface dcache_fill_if;
	import dcache_pkg::*;

	logic       fill_we;     // One strobe per refill word
	dc_way_t    fill_way;    // Way being refilled
	dc_index_t  fill_index;
	dc_offset_t fill_offset; // Word position within the line
	dc_word_t   fill_data;
	logic       fill_done;   // With the last word

	// Miss controller drives everything
	modport ctrl (output fill_we, fill_way, fill_index, fill_offset, fill_data, fill_done);

	// Tag and data arrays
	modport array (input fill_we, fill_way, fill_index, fill_offset, fill_data, fill_done);

	// Recency update only needs where and when
	modport policy (input fill_way, fill_index, fill_done);

endinterface

//--- hw/dcache_miss_ctrl.sv
module dcache_miss_ctrl (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_req_valid,
	input  logic                  i_req_write,
	input  dcache_pkg::dc_addr_u  i_req_addr,
	input  logic                  i_tag_match,
	input  dcache_pkg::dc_way_t   i_victim_way,
	input  logic                  i_victim_valid,
	input  logic                  i_victim_dirty,
	input  dcache_pkg::dc_tag_t   i_victim_tag,
	input  dcache_pkg::dc_line_t  i_victim_line,
	input  logic                  i_mem_rd_gnt,
	input  logic                  i_mem_rvalid,
	input  dcache_pkg::dc_word_t  i_mem_rdata,
	input  logic                  i_mem_wr_gnt,
	input  logic                  i_mem_wready,
	dcache_fill_if.ctrl           fill,
	output logic                  o_rsp_valid,
	output logic                  o_store_en,
	output logic                  o_miss_start,
	output logic                  o_mem_rd_req,
	output dcache_pkg::dc_addr_u  o_mem_rd_addr,
	output logic                  o_mem_wr_req,
	output dcache_pkg::dc_addr_u  o_mem_wr_addr,
	output logic                  o_mem_wvalid,
	output dcache_pkg::dc_word_t  o_mem_wdata,
	output logic                  o_mem_wlast
);
	import dcache_pkg::*;

	dc_state_e  state, next_state;
	dc_tag_t    r_tag;      // Missing line
	dc_index_t  r_index;
	dc_way_t    r_way;      // Way to be replaced
	dc_tag_t    r_vtag;     // Victim tag for the flush address
	dc_line_t   flush_line; // Shift register with word 0 going out first
	dc_offset_t word_cnt;
	logic       hit, miss, last_word;

	// Only place a hit is gated by READY
	assign hit  = i_req_valid && i_tag_match && (state == ST_READY);
	assign miss = i_req_valid && !i_tag_match && (state == ST_READY);
	assign last_word = &word_cnt;

	assign o_rsp_valid  = hit;
	assign o_store_en   = hit && i_req_write;
	assign o_miss_start = miss;

	always_comb begin
		next_state = state;
		unique case (state)
			ST_READY:       if (miss) next_state = (i_victim_valid && i_victim_dirty) ?
						ST_FLUSH_REQ : ST_REFILL_REQ;
			ST_FLUSH_REQ:   if (i_mem_wr_gnt) next_state = ST_FLUSH_DATA;
			ST_FLUSH_DATA:  if (i_mem_wready && last_word) next_state = ST_REFILL_REQ;
			ST_REFILL_REQ:  if (i_mem_rd_gnt) next_state = ST_REFILL_DATA;
			ST_REFILL_DATA: if (i_mem_rvalid && last_word) next_state = ST_READY;
			default:        next_state = ST_READY;
		endcase
	end

	// Line-aligned burst addresses
	always_comb begin
		o_mem_wr_addr         = '0;
		o_mem_wr_addr.f.tag   = r_vtag;
		o_mem_wr_addr.f.index = r_index;
		o_mem_rd_addr         = '0;
		o_mem_rd_addr.f.tag   = r_tag;
		o_mem_rd_addr.f.index = r_index;
	end

	assign o_mem_wr_req = (state == ST_FLUSH_REQ);
	assign o_mem_wvalid = (state == ST_FLUSH_DATA);
	assign o_mem_wdata  = flush_line[0];
	assign o_mem_wlast  = o_mem_wvalid && last_word;
	assign o_mem_rd_req = (state == ST_REFILL_REQ);

	// Refill words straight into the arrays
	assign fill.fill_we     = (state == ST_REFILL_DATA) && i_mem_rvalid;
	assign fill.fill_done   = fill.fill_we && last_word;
	assign fill.fill_way    = r_way;
	assign fill.fill_index  = r_index;
	assign fill.fill_offset = word_cnt;
	assign fill.fill_data   = i_mem_rdata;

	// word_cnt wraps to 0 at the end of every burst
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= ST_READY;
			word_cnt <= '0;
		end else begin
			state <= next_state;
			if ((o_mem_wvalid && i_mem_wready) || fill.fill_we)
				word_cnt <= word_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (miss) begin
			r_tag      <= i_req_addr.f.tag;
			r_index    <= i_req_addr.f.index;
			r_way      <= i_victim_way;
			r_vtag     <= i_victim_tag;
			flush_line <= i_victim_line; // Harmless when clean
		end else if (o_mem_wvalid && i_mem_wready) begin
			flush_line <= {{DC_DATA_W{1'b0}}, flush_line[DC_LINE_WORDS-1:1]};
		end
	end

	a_one_bus_req: assert property (@(posedge clk) disable iff (!rst_n)
		!(o_mem_rd_req && o_mem_wr_req));

endmodule

//--- hw/dcache_pkg.sv
package dcache_pkg;
	// Cache geometry
	localparam int DC_ADDR_W     = 32;
	localparam int DC_DATA_W     = 32;
	localparam int DC_WAYS       = 4;
	localparam int DC_INDEX_W    = 4;
	localparam int DC_SETS       = 1 << DC_INDEX_W; // 16 sets
	localparam int DC_OFFSET_W   = 2;
	localparam int DC_LINE_WORDS = 1 << DC_OFFSET_W;
	localparam int DC_TAG_W      = DC_ADDR_W - DC_INDEX_W - DC_OFFSET_W - 2; // 2 byte bits

	// Set dueling
	localparam int DC_BIP_LEADER   = 8;  // Always BIP
	localparam int DC_LIP_LEADER   = 15; // Always LIP
	localparam int DC_PSEL_W       = 10;
	localparam int DC_PSEL_INIT    = 512; // Midpoint, followers start on BIP
	localparam int DC_BIP_PERIOD_W = 5;   // One MRU insertion per 32 misses

	typedef logic [DC_DATA_W-1:0]   dc_word_t;
	typedef logic [DC_TAG_W-1:0]    dc_tag_t;
	typedef logic [DC_INDEX_W-1:0]  dc_index_t;
	typedef logic [DC_OFFSET_W-1:0] dc_offset_t;
	typedef logic [1:0]             dc_way_t; // log2 of DC_WAYS

	// Same 32 bits seen either as a bus address or as lookup fields
	typedef union packed {
		logic [DC_ADDR_W-1:0] raw;
		struct packed {
			dc_tag_t    tag;
			dc_index_t  index;
			dc_offset_t offset;
			logic [1:0] byte_sel; // Ignored, word accesses only
		} f;
	} dc_addr_u;

	typedef dc_word_t [DC_LINE_WORDS-1:0] dc_line_t; // Word 0 in the low bits

	// Miss FSM
	typedef enum logic [2:0] {
		ST_READY,       // Lookup, hits answered
		ST_FLUSH_REQ,   // Waiting for write grant
		ST_FLUSH_DATA,  // Dirty victim going out
		ST_REFILL_REQ,  // Waiting for read grant
		ST_REFILL_DATA  // Line coming in
	} dc_state_e;

endpackage

//--- hw/dcache_repl_policy.sv
module dcache_repl_policy (
	input  logic                           clk,
	input  logic                           rst_n,
	input  dcache_pkg::dc_index_t          i_index,
	input  logic                           i_hit_resp,  // Hit answered this cycle
	input  dcache_pkg::dc_way_t            i_hit_way,
	input  logic                           i_miss_start,
	input  logic [dcache_pkg::DC_WAYS-1:0] i_way_valid,
	dcache_fill_if.policy                  fill,
	output dcache_pkg::dc_way_t            o_victim_way
);
	import dcache_pkg::*;

	dc_way_t [DC_WAYS-1:0] order [DC_SETS]; // [0] least recent, [DC_WAYS-1] most recent
	logic [DC_PSEL_W-1:0]       psel;
	logic [DC_BIP_PERIOD_W-1:0] bip_ctr;
	logic                       ins_mru;   // Insertion decided at miss start
	logic                       set_bip;
	dc_index_t                  upd_index;
	dc_way_t                    upd_way;
	dc_way_t                    upd_pos;
	logic                       upd_mru;
	dc_way_t [DC_WAYS-1:0]      cur_order;
	dc_way_t [DC_WAYS-1:0]      new_order;
	logic [DC_WAYS-1:0]         way_seen;
	logic                       perm_ok;

	// Leaders are fixed, followers go with the selector
	always_comb begin
		if (i_index == dc_index_t'(DC_BIP_LEADER))
			set_bip = 1'b1;
		else if (i_index == dc_index_t'(DC_LIP_LEADER))
			set_bip = 1'b0;
		else
			set_bip = (psel >= DC_PSEL_W'(DC_PSEL_INIT));
	end

	// Victim: lowest invalid way, else LRU
	always_comb begin
		o_victim_way = order[i_index][0];
		for (int w = DC_WAYS - 1; w >= 0; w--) begin
			if (!i_way_valid[w])
				o_victim_way = dc_way_t'(w);
		end
	end

	// Hit and fill_done never coincide
	assign upd_index = fill.fill_done ? fill.fill_index : i_index;
	assign upd_way   = fill.fill_done ? fill.fill_way : i_hit_way;
	assign upd_mru   = fill.fill_done ? ins_mru : 1'b1; // Hits always promote

	always_comb begin
		cur_order = order[upd_index];
		upd_pos   = '0;
		for (int p = 0; p < DC_WAYS; p++) begin
			if (cur_order[p] == upd_way)
				upd_pos = dc_way_t'(p);
		end
		new_order = cur_order;
		if (upd_mru) begin
			for (int p = 0; p < DC_WAYS - 1; p++) begin
				if (p >= upd_pos)
					new_order[p] = cur_order[p+1]; // Close the gap
			end
			new_order[DC_WAYS-1] = upd_way;
		end else begin
			for (int p = 1; p < DC_WAYS; p++) begin
				if (p <= upd_pos)
					new_order[p] = cur_order[p-1]; // Push older ones up
			end
			new_order[0] = upd_way;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int s = 0; s < DC_SETS; s++)
				for (int p = 0; p < DC_WAYS; p++)
					order[s][p] <= dc_way_t'(p); // Way 0 LRU
		end else if (i_hit_resp || fill.fill_done) begin
			order[upd_index] <= new_order;
		end
	end

	// Selector counts leader misses only
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			psel    <= DC_PSEL_W'(DC_PSEL_INIT);
			bip_ctr <= '0;
			ins_mru <= 1'b0;
		end else if (i_miss_start) begin
			if (i_index == dc_index_t'(DC_BIP_LEADER) && psel != '0)
				psel <= psel - 1'b1; // BIP missed, lean to LIP
			else if (i_index == dc_index_t'(DC_LIP_LEADER) && psel != '1)
				psel <= psel + 1'b1;
			bip_ctr <= bip_ctr + 1'b1; // Every miss
			ins_mru <= set_bip && (bip_ctr == '0); // Selector value before this miss
		end
	end

	// Every set must keep each way exactly once
	always_comb begin
		perm_ok  = 1'b1;
		way_seen = '0;
		for (int s = 0; s < DC_SETS; s++) begin
			way_seen = '0;
			for (int p = 0; p < DC_WAYS; p++)
				way_seen[order[s][p]] = 1'b1;
			if (way_seen != '1)
				perm_ok = 1'b0;
		end
	end

	a_order_perm: assert property (@(posedge clk) disable iff (!rst_n) perm_ok);

endmodule

//--- hw/dcache_tag_array.sv
module dcache_tag_array (
	input  logic                             clk,
	input  logic                             rst_n,
	input  dcache_pkg::dc_index_t            i_index,
	input  dcache_pkg::dc_tag_t              i_tag,
	input  logic                             i_store_en,   // Store hit this cycle
	input  dcache_pkg::dc_way_t              i_victim_way,
	dcache_fill_if.array                     fill,
	output logic                             o_tag_match,
	output dcache_pkg::dc_way_t              o_match_way,
	output logic [dcache_pkg::DC_WAYS-1:0]   o_way_valid,
	output logic                             o_victim_valid,
	output logic                             o_victim_dirty,
	output dcache_pkg::dc_tag_t              o_victim_tag
);
	import dcache_pkg::*;

	dc_tag_t            tag_mem [DC_WAYS][DC_SETS];
	logic [DC_SETS-1:0] valid   [DC_WAYS]; // valid[way][set]
	logic [DC_SETS-1:0] dirty   [DC_WAYS];
	logic [DC_WAYS-1:0] way_hit;

	// Compare all ways at once
	always_comb begin
		for (int w = 0; w < DC_WAYS; w++) begin
			o_way_valid[w] = valid[w][i_index];
			way_hit[w]     = valid[w][i_index] && (tag_mem[w][i_index] == i_tag);
		end
	end

	// Encode hit vector, at most one bit set
	always_comb begin
		o_match_way = '0;
		for (int w = 0; w < DC_WAYS; w++) begin
			if (way_hit[w])
				o_match_way = dc_way_t'(w);
		end
	end

	assign o_tag_match = |way_hit;

	// Victim state for the flush decision
	assign o_victim_valid = valid[i_victim_way][i_index];
	assign o_victim_dirty = dirty[i_victim_way][i_index];
	assign o_victim_tag   = tag_mem[i_victim_way][i_index];

	// Request is held through the miss, so i_tag is still the missing tag
	always_ff @(posedge clk) begin
		if (fill.fill_done)
			tag_mem[fill.fill_way][fill.fill_index] <= i_tag;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int w = 0; w < DC_WAYS; w++) begin
				valid[w] <= '0;
				dirty[w] <= '0;
			end
		end else begin
			if (fill.fill_done) begin
				valid[fill.fill_way][fill.fill_index] <= 1'b1; // Fresh line
				dirty[fill.fill_way][fill.fill_index] <= 1'b0;
			end else if (i_store_en) begin
				dirty[o_match_way][i_index] <= 1'b1; // Write-back, mark only
			end
		end
	end

	// Victim choice must never leave two copies of a line in one set
	a_single_match: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(way_hit));

endmodule

//--- hw/dcache_top.sv
module dcache_top (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                i_req_valid,
	input  logic                                i_req_write,
	input  dcache_pkg::dc_addr_u                i_req_addr,
	input  dcache_pkg::dc_word_t                i_req_wdata,
	output logic                                o_rsp_valid,
	output dcache_pkg::dc_word_t                o_rsp_rdata,
	output logic                                o_mem_rd_req,
	output logic [dcache_pkg::DC_ADDR_W-1:0]    o_mem_rd_addr,
	input  logic                                i_mem_rd_gnt,
	input  logic                                i_mem_rvalid,
	input  dcache_pkg::dc_word_t                i_mem_rdata,
	output logic                                o_mem_wr_req,
	output logic [dcache_pkg::DC_ADDR_W-1:0]    o_mem_wr_addr,
	input  logic                                i_mem_wr_gnt,
	output logic                                o_mem_wvalid,
	output dcache_pkg::dc_word_t                o_mem_wdata,
	output logic                                o_mem_wlast,
	input  logic                                i_mem_wready
);
	import dcache_pkg::*;

	logic               tag_match;
	dc_way_t            match_way;
	logic [DC_WAYS-1:0] way_valid;
	logic               victim_valid;
	logic               victim_dirty;
	dc_tag_t            victim_tag;
	dc_way_t            victim_way;   // From the policy, for the current set
	dc_line_t           victim_line;
	logic               store_en;
	logic               miss_start;
	dc_addr_u           rd_addr;
	dc_addr_u           wr_addr;

	dcache_fill_if u_fill ();

	dcache_tag_array u_tags (
		.clk, .rst_n,
		.i_index        (i_req_addr.f.index),
		.i_tag          (i_req_addr.f.tag),
		.i_store_en     (store_en),
		.i_victim_way   (victim_way),
		.fill           (u_fill),
		.o_tag_match    (tag_match),
		.o_match_way    (match_way),
		.o_way_valid    (way_valid),
		.o_victim_valid (victim_valid),
		.o_victim_dirty (victim_dirty),
		.o_victim_tag   (victim_tag)
	);

	dcache_data_array u_data (
		.clk,
		.i_index       (i_req_addr.f.index),
		.i_offset      (i_req_addr.f.offset),
		.i_way         (match_way),
		.i_store_en    (store_en),
		.i_store_data  (i_req_wdata),
		.i_victim_way  (victim_way),
		.fill          (u_fill),
		.o_rdata       (o_rsp_rdata),   // Valid with o_rsp_valid
		.o_victim_line (victim_line)
	);

	dcache_repl_policy u_policy (
		.clk, .rst_n,
		.i_index      (i_req_addr.f.index),
		.i_hit_resp   (o_rsp_valid),
		.i_hit_way    (match_way),
		.i_miss_start (miss_start),
		.i_way_valid  (way_valid),
		.fill         (u_fill),
		.o_victim_way (victim_way)
	);

	dcache_miss_ctrl u_ctrl (
		.clk, .rst_n,
		.i_req_valid, .i_req_write, .i_req_addr,
		.i_tag_match    (tag_match),
		.i_victim_way   (victim_way),
		.i_victim_valid (victim_valid),
		.i_victim_dirty (victim_dirty),
		.i_victim_tag   (victim_tag),
		.i_victim_line  (victim_line),
		.i_mem_rd_gnt, .i_mem_rvalid, .i_mem_rdata,
		.i_mem_wr_gnt, .i_mem_wready,
		.fill           (u_fill),
		.o_rsp_valid,
		.o_store_en     (store_en),
		.o_miss_start   (miss_start),
		.o_mem_rd_req,
		.o_mem_rd_addr  (rd_addr),
		.o_mem_wr_req,
		.o_mem_wr_addr  (wr_addr),
		.o_mem_wvalid, .o_mem_wdata, .o_mem_wlast
	);

	// Flat address words on the memory side
	assign o_mem_rd_addr = rd_addr.raw;
	assign o_mem_wr_addr = wr_addr.raw;

endmodule
